//--- burst_store.sv
module burst_store (
  input  logic                                     c0_ddr4_ui_clk,
  input  logic                                     rst,
  input  logic                                     read_en,        // read-out allowed
  input  ddr_buf_pkg::line_t                       wr_fifo_data,   // write fifo head
  input  logic [ddr_buf_pkg::fifo_count_width-1:0] wr_fifo_count,
  input  logic [ddr_buf_pkg::fifo_count_width-1:0] rd_fifo_count,
  output logic                                     wr_fifo_pop,    // one line per beat
  output ddr_buf_pkg::line_t                       rd_fifo_data,
  output logic                                     rd_fifo_push
);

  typedef enum logic [1:0] {
    st_idle,  // waiting for a burst
    st_wr,    // write fifo into ring
    st_rd     // ring into read fifo
  } state_t;

  state_t                                     state;
  logic [ddr_buf_pkg::beat_width-1:0]         beat;        // line within burst
  logic [ddr_buf_pkg::store_addr_width-1:0]   wr_addr;     // ring write address
  logic [ddr_buf_pkg::store_addr_width-1:0]   rd_addr;     // ring read address
  logic [ddr_buf_pkg::stored_width-1:0]       stored;      // unread lines in ring
  logic [ddr_buf_pkg::fifo_count_width:0]     rd_pending;  // read fifo incl. push in flight
  logic                                       wr_start;
  logic                                       rd_start;
  logic                                       rd_room;
  logic                                       rd_beat;
  logic                                       last_beat;

  ddr_buf_pkg::line_t mem [ddr_buf_pkg::store_lines];     // line ring, stands in for ddr

  // ==============================
  // burst arbitration
  // ==============================
  // last push of a read burst lands after the burst ends
  assign rd_pending = {1'b0, rd_fifo_count}
                    + {{ddr_buf_pkg::fifo_count_width{1'b0}}, rd_fifo_push};
  assign rd_room    = rd_pending <= (ddr_buf_pkg::fifo_depth - ddr_buf_pkg::burst_len);
  assign wr_start   = (state == st_idle) && (wr_fifo_count >= ddr_buf_pkg::burst_len);
  assign rd_start   = (state == st_idle) && !wr_start && read_en
                    && (stored >= ddr_buf_pkg::burst_len) && rd_room;  // writes first
  assign wr_fifo_pop = (state == st_wr);  // head consumed every write beat
  assign rd_beat     = (state == st_rd);
  assign last_beat   = (beat == ddr_buf_pkg::burst_len - 1);

  always_ff @(posedge c0_ddr4_ui_clk)
  begin
    if (rst)
    begin
      state <= st_idle;
      beat  <= '0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          beat <= '0;
          if (wr_start)
          begin
            state <= st_wr;
          end
          else if (rd_start)
          begin
            state <= st_rd;
          end
        end
        st_wr, st_rd:
        begin
          beat <= beat + 1'b1;
          if (last_beat)
          begin
            state <= st_idle;  // whole burst done
            beat  <= '0;
          end
        end
        default:
        begin
          state <= st_idle;
        end
      endcase
    end
  end

  // ==============================
  // ring addressing
  // ==============================
  always_ff @(posedge c0_ddr4_ui_clk)
  begin
    if (rst)
    begin
      wr_addr      <= '0;
      rd_addr      <= '0;
      stored       <= '0;
      rd_fifo_push <= 1'b0;
    end
    else
    begin
      rd_fifo_push <= rd_beat;              // data follows memory read
      if (wr_fifo_pop)
      begin
        wr_addr <= wr_addr + 1'b1;          // wraps at store_lines
        stored  <= stored + 1'b1;
      end
      else if (rd_beat)
      begin
        rd_addr <= rd_addr + 1'b1;
        stored  <= stored - 1'b1;
      end
    end
  end

  // line memory, payload only
  always_ff @(posedge c0_ddr4_ui_clk)
  begin
    if (wr_fifo_pop)
    begin
      mem[wr_addr] <= wr_fifo_data;
    end
    if (rd_beat)
    begin
      rd_fifo_data <= mem[rd_addr];         // one cycle read latency
    end
  end

endmodule

//--- ddr_buf_pkg.sv
package ddr_buf_pkg;

  // ==============================
  // data widths
  // ==============================
  localparam int word_width     = 32;                          // one stream word
  localparam int words_per_line = 4;                           // words packed per line
  localparam int line_width     = word_width * words_per_line; // 128 bit memory line
  localparam int word_idx_width = $clog2(words_per_line);      // word slot select

  // ==============================
  // burst and storage sizes
  // ==============================
  localparam int burst_len        = 4;                          // lines per burst
  localparam int beat_width       = $clog2(burst_len);          // beat counter
  localparam int fifo_depth       = 16;                         // lines per fifo
  localparam int fifo_count_width = $clog2(fifo_depth + 1);     // 0..fifo_depth
  localparam int store_lines      = 64;                         // ring depth in lines
  localparam int store_addr_width = $clog2(store_lines);        // ring address
  localparam int stored_width     = $clog2(store_lines + 1);    // unread line count
  localparam int count_width      = 32;                         // accepted word counter

  // word 0 sits in bits [word_width-1:0]
  typedef logic [line_width-1:0] line_t;

endpackage

//--- ddr_loop_buffer.sv
module ddr_loop_buffer (
  input  logic                                c0_ddr4_ui_clk,
  input  logic                                rst,
  input  logic [ddr_buf_pkg::word_width-1:0]  wr_data_in,
  input  logic                                wr_data_in_valid,
  input  logic                                start_work,
  input  logic [ddr_buf_pkg::count_width-1:0] delay_thread,
  output logic [ddr_buf_pkg::word_width-1:0]  rd_data_out,
  output logic                                rd_data_out_valid
);

  ddr_buf_pkg::line_t                       line_data;      // packer to write fifo
  logic                                     line_valid;
  logic                                     read_en;        // threshold reached
  ddr_buf_pkg::line_t                       wr_fifo_data;   // write fifo head
  logic [ddr_buf_pkg::fifo_count_width-1:0] wr_fifo_count;
  logic                                     wr_fifo_pop;
  ddr_buf_pkg::line_t                       rd_fifo_data;   // store to read fifo
  logic                                     rd_fifo_push;
  ddr_buf_pkg::line_t                       rd_fifo_head;   // read fifo head
  logic [ddr_buf_pkg::fifo_count_width-1:0] rd_fifo_count;
  logic                                     rd_fifo_pop;

  // ==============================
  // write side
  // ==============================
  intake_packer u_intake_packer (
    .c0_ddr4_ui_clk   (c0_ddr4_ui_clk),
    .rst              (rst),
    .wr_data_in       (wr_data_in),
    .wr_data_in_valid (wr_data_in_valid),
    .start_work       (start_work),
    .delay_thread     (delay_thread),
    .line_data        (line_data),
    .line_valid       (line_valid),
    .read_en          (read_en)
  );

  line_fifo #(
    .payload_t (ddr_buf_pkg::line_t),
    .depth     (ddr_buf_pkg::fifo_depth)
  ) wr_line_fifo (
    .c0_ddr4_ui_clk (c0_ddr4_ui_clk),
    .rst            (rst),
    .push           (line_valid),
    .push_data      (line_data),
    .pop            (wr_fifo_pop),
    .head           (wr_fifo_data),
    .count          (wr_fifo_count)
  );

  // ==============================
  // line store and read side
  // ==============================
  burst_store u_burst_store (
    .c0_ddr4_ui_clk (c0_ddr4_ui_clk),
    .rst            (rst),
    .read_en        (read_en),
    .wr_fifo_data   (wr_fifo_data),
    .wr_fifo_count  (wr_fifo_count),
    .rd_fifo_count  (rd_fifo_count),
    .wr_fifo_pop    (wr_fifo_pop),
    .rd_fifo_data   (rd_fifo_data),
    .rd_fifo_push   (rd_fifo_push)
  );

  line_fifo #(
    .payload_t (ddr_buf_pkg::line_t),
    .depth     (ddr_buf_pkg::fifo_depth)
  ) rd_line_fifo (
    .c0_ddr4_ui_clk (c0_ddr4_ui_clk),
    .rst            (rst),
    .push           (rd_fifo_push),
    .push_data      (rd_fifo_data),
    .pop            (rd_fifo_pop),
    .head           (rd_fifo_head),
    .count          (rd_fifo_count)
  );

  line_unpacker u_line_unpacker (
    .c0_ddr4_ui_clk    (c0_ddr4_ui_clk),
    .rst               (rst),
    .rd_fifo_head      (rd_fifo_head),
    .rd_fifo_count     (rd_fifo_count),
    .rd_fifo_pop       (rd_fifo_pop),
    .rd_data_out       (rd_data_out),
    .rd_data_out_valid (rd_data_out_valid)
  );

endmodule

//--- intake_packer.sv
module intake_packer (
  input  logic                                c0_ddr4_ui_clk,
  input  logic                                rst,
  input  logic [ddr_buf_pkg::word_width-1:0]  wr_data_in,       // incoming word
  input  logic                                wr_data_in_valid,
  input  logic                                start_work,       // intake gate
  input  logic [ddr_buf_pkg::count_width-1:0] delay_thread,     // read-out threshold
  output ddr_buf_pkg::line_t                  line_data,        // packed line
  output logic                                line_valid,       // one cycle push
  output logic                                read_en           // sticky until reset
);

  ddr_buf_pkg::line_t                       line_reg;   // line under assembly
  logic [ddr_buf_pkg::word_idx_width-1:0]   word_idx;   // next word slot
  logic [ddr_buf_pkg::count_width-1:0]      wr_cnt;     // accepted words so far
  logic                                     accept;
  logic                                     last_word;

  assign accept    = start_work && wr_data_in_valid;                  // gated intake
  assign last_word = (word_idx == ddr_buf_pkg::words_per_line - 1);   // slot 3
  assign line_data = line_reg;

  // ==============================
  // packing
  // ==============================
  // payload only, slot select comes from word_idx
  always_ff @(posedge c0_ddr4_ui_clk)
  begin
    if (accept)
    begin
      line_reg[word_idx*ddr_buf_pkg::word_width +: ddr_buf_pkg::word_width] <= wr_data_in;
    end
  end

  always_ff @(posedge c0_ddr4_ui_clk)
  begin
    if (rst)
    begin
      word_idx   <= '0;
      line_valid <= 1'b0;
    end
    else
    begin
      line_valid <= accept && last_word;  // line complete next cycle
      if (accept)
      begin
        word_idx <= word_idx + 1'b1;      // wraps after slot 3
      end
    end
  end

  // ==============================
  // word count and read enable
  // ==============================
  always_ff @(posedge c0_ddr4_ui_clk)
  begin
    if (rst)
    begin
      wr_cnt <= '0;
    end
    else if (accept)
    begin
      wr_cnt <= wr_cnt + 1'b1;            // one per accepted word
    end
  end

  always_ff @(posedge c0_ddr4_ui_clk)
  begin
    if (rst)
    begin
      read_en <= 1'b0;
    end
    else if (wr_cnt >= delay_thread)
    begin
      read_en <= 1'b1;                    // latches, never clears
    end
  end

endmodule

//--- line_fifo.sv
module line_fifo #(
  parameter type payload_t = logic,  // entry type
  parameter int  depth     = 16      // entries
) (
  input  logic                       c0_ddr4_ui_clk,
  input  logic                       rst,
  input  logic                       push,       // write strobe
  input  payload_t                   push_data,
  input  logic                       pop,        // advance head
  output payload_t                   head,       // oldest entry
  output logic [$clog2(depth+1)-1:0] count       // occupancy
);

  payload_t                   mem [depth];    // entry storage
  logic [$clog2(depth)-1:0]   wr_ptr;         // next free slot
  logic [$clog2(depth)-1:0]   rd_ptr;         // oldest slot
  logic                       do_push;
  logic                       do_pop;

  assign do_push = push && (count != depth);  // drop when full
  assign do_pop  = pop && (count != 0);       // ignore when empty
  assign head    = mem[rd_ptr];               // next entry visible after pop

  // storage write
  always_ff @(posedge c0_ddr4_ui_clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= push_data;
    end
  end

  // ==============================
  // pointers and occupancy
  // ==============================
  always_ff @(posedge c0_ddr4_ui_clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;  // wrap at depth
      end
      if (do_pop)
      begin
        rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;         // none or both
      endcase
    end
  end

endmodule

//--- line_unpacker.sv
module line_unpacker (
  input  logic                                     c0_ddr4_ui_clk,
  input  logic                                     rst,
  input  ddr_buf_pkg::line_t                       rd_fifo_head,     // read fifo head
  input  logic [ddr_buf_pkg::fifo_count_width-1:0] rd_fifo_count,
  output logic                                     rd_fifo_pop,
  output logic [ddr_buf_pkg::word_width-1:0]       rd_data_out,      // word stream
  output logic                                     rd_data_out_valid
);

  ddr_buf_pkg::line_t                       line_hold;  // line being split
  logic [ddr_buf_pkg::word_idx_width-1:0]   word_idx;   // word on the output
  logic                                     busy;       // line in progress
  logic                                     last_word;

  assign last_word = busy && (word_idx == ddr_buf_pkg::words_per_line - 1);

  // take the next line on the last word so lines run back to back
  assign rd_fifo_pop = (!busy || last_word) && (rd_fifo_count != 0);

  assign rd_data_out       = line_hold[word_idx*ddr_buf_pkg::word_width +: ddr_buf_pkg::word_width];
  assign rd_data_out_valid = busy;

  // ==============================
  // word sequencing
  // ==============================
  always_ff @(posedge c0_ddr4_ui_clk)
  begin
    if (rst)
    begin
      busy     <= 1'b0;
      word_idx <= '0;
    end
    else if (rd_fifo_pop)
    begin
      busy     <= 1'b1;                  // start with word 0
      word_idx <= '0;
    end
    else if (busy)
    begin
      word_idx <= word_idx + 1'b1;
      if (last_word)
      begin
        busy <= 1'b0;                    // fifo empty, go idle
      end
    end
  end

  always_ff @(posedge c0_ddr4_ui_clk)
  begin
    if (rd_fifo_pop)
    begin
      line_hold <= rd_fifo_head;         // capture before head moves
    end
  end

endmodule

//--- project.f
ddr_buf_pkg.sv
line_fifo.sv
intake_packer.sv
burst_store.sv
line_unpacker.sv
ddr_loop_buffer.sv
tb_ddr_loop_buffer.sv

//--- tb_ddr_loop_buffer.sv
module tb_ddr_loop_buffer;

  // 6 + 40 + 8 words in the first run, 20 + 6 + 20 + 24 in the second
  localparam int words_driven = 124;
  localparam int cycle_limit  = 20 * words_driven + 200;

  logic                                c0_ddr4_ui_clk;
  logic                                rst = 1'b1;
  logic [ddr_buf_pkg::word_width-1:0]  wr_data_in;
  logic                                wr_data_in_valid;
  logic                                start_work;
  logic [ddr_buf_pkg::count_width-1:0] delay_thread;
  logic [ddr_buf_pkg::word_width-1:0]  rd_data_out;
  logic                                rd_data_out_valid;

  logic [ddr_buf_pkg::word_width-1:0]  expect_q [$];  // accepted words, oldest first
  logic [ddr_buf_pkg::word_width-1:0]  exp_word;
  integer                              seed;          // $random state
  int                                  errors;
  int                                  accepted_cnt;  // words taken with start_work high
  int                                  out_cnt;       // words seen on the output
  int                                  cycle_cnt;
  logic                                stim_started;  // first word driven since reset

  ddr_loop_buffer DUT (
    .c0_ddr4_ui_clk    (c0_ddr4_ui_clk),
    .rst               (rst),
    .wr_data_in        (wr_data_in),
    .wr_data_in_valid  (wr_data_in_valid),
    .start_work        (start_work),
    .delay_thread      (delay_thread),
    .rd_data_out       (rd_data_out),
    .rd_data_out_valid (rd_data_out_valid)
  );

  initial
  begin
    c0_ddr4_ui_clk = 1'b0;
    forever #20 c0_ddr4_ui_clk = ~c0_ddr4_ui_clk;  // period 40
  end

  // ==============================
  // scoreboard and checks
  // ==============================
  // negedge sampling, inputs and outputs both settled here
  always @(negedge c0_ddr4_ui_clk)
  begin
    if (rst)
    begin
      expect_q.delete();                           // dut forgets everything
      accepted_cnt = 0;
      out_cnt      = 0;
    end
    else
    begin
      if (rd_data_out_valid)
      begin
        assert (stim_started)
        else
        begin
          errors++;
          $display("output word appeared before any stimulus was driven");
        end
        assert (accepted_cnt >= delay_thread)
        else
        begin
          errors++;
          $display("output word appeared after only %0d accepted words", accepted_cnt);
        end
        assert (expect_q.size() != 0)
        else
        begin
          errors++;
          $display("output word 0x%08h with no accepted word waiting", rd_data_out);
        end
        if (expect_q.size() != 0)
        begin
          exp_word = expect_q.pop_front();           // oldest accepted word
          assert (rd_data_out == exp_word)
          else
          begin
            errors++;
            $display("Mismatch rd_data_out: got 0x%08h expected 0x%08h",
                     rd_data_out, exp_word);
          end
        end
        out_cnt++;
      end
      if (start_work && wr_data_in_valid)
      begin
        expect_q.push_back(wr_data_in);             // taken at the next rising edge
        accepted_cnt++;
      end
    end
  end

  // ==============================
  // stimulus tasks
  // ==============================
  task automatic apply_reset(input int delay);
    rst              = 1'b1;
    stim_started     = 1'b0;
    wr_data_in       = '0;
    wr_data_in_valid = 1'b0;
    start_work       = 1'b0;
    delay_thread     = delay;
    repeat (2) @(posedge c0_ddr4_ui_clk);
    #1;
    rst = 1'b0;
  endtask

  // one word per valid pulse, at least one idle cycle between words
  task automatic send_words(input int n, input logic gate);
    int i;
    int gap;
    for (i = 0; i < n; i++)
    begin
      @(posedge c0_ddr4_ui_clk);
      #1;
      wr_data_in       = $random(seed);
      wr_data_in_valid = 1'b1;
      start_work       = gate;
      stim_started     = 1'b1;
      @(posedge c0_ddr4_ui_clk);
      #1;
      wr_data_in_valid = 1'b0;
      gap = $unsigned($random(seed)) % 3;           // 0..2 extra idle cycles
      repeat (gap) @(posedge c0_ddr4_ui_clk);
    end
  endtask

  task automatic wait_for_outputs(input int n);
    while (out_cnt < n)
    begin
      @(posedge c0_ddr4_ui_clk);                   // watchdog covers a stall
    end
  endtask

  // give stray words time to show up, then compare totals
  task automatic check_totals(input int exp_out, input int exp_held);
    repeat (100) @(posedge c0_ddr4_ui_clk);
    assert (out_cnt == exp_out)
    else
    begin
      errors++;
      $display("Mismatch rd_data_out_valid count: got 0x%0h expected 0x%0h",
               out_cnt, exp_out);
    end
    assert (expect_q.size() == exp_held)
    else
    begin
      errors++;
      $display("%0d words held inside the buffer, %0d expected", expect_q.size(), exp_held);
    end
  endtask

  // ==============================
  // test sequence
  // ==============================
  initial
  begin
    errors = 0;
    seed   = 69;
    apply_reset(48);
    repeat (5) @(posedge c0_ddr4_ui_clk);          // idle, output must stay quiet
    send_words(6, 1'b0);                           // gated off, never stored
    send_words(40, 1'b1);
    check_totals(0, 40);                           // threshold 48 not reached
    send_words(8, 1'b1);
    wait_for_outputs(48);
    check_totals(48, 0);                           // three whole bursts

    #1;
    apply_reset(16);
    send_words(20, 1'b1);
    send_words(6, 1'b0);
    send_words(20, 1'b1);
    wait_for_outputs(32);
    check_totals(32, 8);                           // ten lines, two bursts out
    send_words(24, 1'b1);
    wait_for_outputs(64);
    check_totals(64, 0);

    $display("error count %0d", errors);
    if (errors == 0)
    begin
      $display("TESTS PASSED");
    end
    else
    begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog
  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < cycle_limit)
    begin
      @(posedge c0_ddr4_ui_clk);
      cycle_cnt++;
    end
    $display("run did not finish within %0d cycles", cycle_limit);
    $display("error count %0d", errors + 1);
    $display("TESTS FAILED");
    $finish;
  end

endmodule
